//--- Makefile
TOP := tb_ow_slave

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f ow_slave_top.f
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Result: FAILED" sim.log || \
		! grep -q "Result: PASSED" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- ow_bus_pkg.sv
package ow_bus_pkg;

    // Slave protocol engine states
    typedef enum logic [3:0] {
        ST_IDLE_WAIT    = 4'd0,  // Line must be idle high before arming
        ST_ARMED        = 4'd1,  // Waiting for the master to pull low
        ST_RESET_LOW    = 4'd2,  // Timing the master low pulse
        ST_RELEASE_WAIT = 4'd3,  // Reset long enough, waiting for release
        ST_PRES_DELAY   = 4'd4,
        ST_PRES_DRIVE   = 4'd5,  // Slave holds the line low
        ST_HIGH_WAIT    = 4'd6,  // Between write slots
        ST_SLOT_LOW     = 4'd7,
        ST_ERROR        = 4'd8
    } ow_state_t;

    // Line condition seen by the engine in one cycle
    typedef enum logic [1:0] {
        EVT_LOW  = 2'd0,
        EVT_HIGH = 2'd1,
        EVT_FALL = 2'd2   // Filtered falling edge, takes priority
    } ow_line_evt_t;

endpackage

//--- ow_config.svh
`ifndef OW_CONFIG_SVH
`define OW_CONFIG_SVH

// Bus timings in 25 MHz clock cycles

// Line must be high this long before the slave arms
`define OW_IDLE_HIGH      100
`define OW_RESET_MIN      11500   // ~460 us master reset low
`define OW_PRESENCE_WAIT  1125    // ~45 us from release to presence
`define OW_PRESENCE_LEN   6000    // ~240 us presence pulse
`define OW_SAMPLE_POINT   800     // ~32 us into the write slot
`define OW_SLOT_MAX       2500    // Longest legal low inside a slot
`define OW_TIMEOUT        30000   // ~1.2 ms waiting for a high line

// Cycles a new level must hold before the filter takes it
`define OW_GLITCH_LEN     3

// Frame size
`define OW_FRAME_BYTES    2

`endif

//--- ow_frame_assembler.sv
`timescale 1ns/100ps
`include "ow_config.svh"

module ow_frame_assembler
    import ow_frame_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     rx_valid,
    input  logic     frame_start,
    input  logic     frame_ack,
    input  ow_byte_t rx_byte,
    output ow_word_t frame_word,
    output logic     frame_req,
    output logic     overrun
);

    localparam ow_byte_idx_t FRAME_BYTES = ow_byte_idx_t'(`OW_FRAME_BYTES);
    localparam ow_byte_idx_t LAST_IDX    = ow_byte_idx_t'(`OW_FRAME_BYTES - 1);

    ow_byte_idx_t byte_idx;
    ow_word_t     asm_word;   // Bytes gathered so far
    ow_word_t     merged;     // asm_word with the incoming byte in its lane
    logic         lane_wr;
    logic         last_byte;
    logic         hs_busy;
    logic         commit;

    // ==============================
    // Byte lanes
    // ==============================
    always_comb begin
        merged = asm_word;
        for (int i = 0; i < `OW_FRAME_BYTES; i++) begin
            if (byte_idx == ow_byte_idx_t'(i)) begin
                merged[i*8 +: 8] = rx_byte;
            end
        end
    end

    assign lane_wr   = rx_valid && (byte_idx < FRAME_BYTES);
    assign last_byte = rx_valid && (byte_idx == LAST_IDX);
    assign hs_busy   = frame_req || frame_ack;  // Four-phase cycle not finished
    assign commit    = last_byte && !hs_busy;

    always_ff @(posedge clk) begin
        if (lane_wr) begin
            asm_word <= merged;
        end
        if (commit) begin
            frame_word <= merged;
        end
    end

    // ==============================
    // Index and handshake
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            byte_idx  <= '0;
            frame_req <= 1'b0;
            overrun   <= 1'b0;
        end else begin
            if (frame_start) begin
                byte_idx <= '0;
            end else if (lane_wr) begin
                byte_idx <= byte_idx + 1'b1;
            end
            if (commit) begin
                frame_req <= 1'b1;
            end else if (frame_ack) begin
                frame_req <= 1'b0;  // Phase 3, ack seen
            end
            if (last_byte && hs_busy) begin
                overrun <= 1'b1;  // New word dropped, old one kept
            end
        end
    end

    a_word_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (frame_req && $past(frame_req)) |-> (frame_word == $past(frame_word))
    );

    a_no_req_during_ack: assert property (
        @(posedge clk) disable iff (!rst_n)
        (!frame_req && frame_ack) |=> !frame_req
    );

endmodule

//--- ow_frame_pkg.sv
package ow_frame_pkg;

    // One byte as it comes off the bus
    typedef logic [7:0] ow_byte_t;

    // Control word, first received byte in the low half
    typedef logic [15:0] ow_word_t;

    // Position of a byte within the frame
    typedef logic [3:0] ow_byte_idx_t;

endpackage

//--- ow_line_io.sv
`timescale 1ns/100ps
`include "ow_config.svh"

module ow_line_io (
    input  logic clk,
    input  logic rst_n,
    input  logic pull_low,
    inout  wire  dq,
    output logic line_lvl,
    output logic line_fall
);

    localparam int CNT_W = $clog2(`OW_GLITCH_LEN + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`OW_GLITCH_LEN - 1);

    logic [1:0]       sync_q;      // Two-stage synchroniser
    logic [CNT_W-1:0] stable_cnt;

    // Open drain, only ever pulls toward ground
    assign dq = pull_low ? 1'b0 : 1'bz;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q     <= 2'b11;  // Bus idles high
            stable_cnt <= '0;
            line_lvl   <= 1'b1;
            line_fall  <= 1'b0;
        end else begin
            sync_q    <= {sync_q[0], dq};
            line_fall <= 1'b0;
            if (sync_q[1] == line_lvl) begin
                stable_cnt <= '0;  // Glitch gone, start over
            end else if (stable_cnt == CNT_LAST) begin
                stable_cnt <= '0;
                line_lvl   <= sync_q[1];
                line_fall  <= line_lvl;  // Old level high means falling edge
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

    // A new filtered level needs a full stable run of the synchronised input
    a_filter_run: assert property (
        @(posedge clk) disable iff (!rst_n)
        $changed(line_lvl) |-> $past(sync_q[1] != line_lvl, `OW_GLITCH_LEN)
    );

endmodule

//--- ow_slave_fsm.sv
`timescale 1ns/100ps
`include "ow_config.svh"

module ow_slave_fsm
    import ow_bus_pkg::*;
    import ow_frame_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     line_lvl,
    input  logic     line_fall,
    output logic     pull_low,
    output logic     rx_valid,
    output logic     frame_start,
    output logic     error,
    output ow_byte_t rx_byte
);

    // Terminal counts, the timer reads 0 one cycle after entering a state
    localparam logic [14:0] IDLE_END    = 15'(`OW_IDLE_HIGH - 1);
    localparam logic [14:0] RESET_END   = 15'(`OW_RESET_MIN - 1);
    localparam logic [14:0] PWAIT_END   = 15'(`OW_PRESENCE_WAIT - 2);
    localparam logic [14:0] PLEN_END    = 15'(`OW_PRESENCE_LEN - 1);
    localparam logic [14:0] SAMPLE_AT   = 15'(`OW_SAMPLE_POINT - 2);
    localparam logic [14:0] SLOT_END    = 15'(`OW_SLOT_MAX - 1);
    localparam logic [14:0] TIMEOUT_END = 15'(`OW_TIMEOUT - 1);
    localparam ow_byte_idx_t LAST_BYTE  = ow_byte_idx_t'(`OW_FRAME_BYTES - 1);

    ow_state_t    state;
    ow_line_evt_t line_evt;
    logic [14:0]  timer;      // Shared by every timed state
    logic [2:0]   bit_cnt;
    ow_byte_idx_t byte_cnt;
    logic         bit_taken;  // Current slot already sampled
    ow_byte_t     shreg;
    logic         sample_now;
    logic         bit_done;
    logic         byte_done;

    // ==============================
    // Line classification
    // ==============================
    always_comb begin
        if (line_fall) begin
            line_evt = EVT_FALL;
        end else if (line_lvl) begin
            line_evt = EVT_HIGH;
        end else begin
            line_evt = EVT_LOW;
        end
    end

    assign sample_now = (state == ST_SLOT_LOW) && (timer == SAMPLE_AT);
    assign bit_done   = (state == ST_SLOT_LOW) && bit_taken && line_lvl;
    assign byte_done  = bit_done && (bit_cnt == 3'd7);

    // ==============================
    // Protocol engine
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ST_IDLE_WAIT;
            timer       <= '0;
            bit_cnt     <= '0;
            byte_cnt    <= '0;
            bit_taken   <= 1'b0;
            pull_low    <= 1'b0;
            rx_valid    <= 1'b0;
            frame_start <= 1'b0;
            error       <= 1'b0;
        end else begin
            rx_valid    <= 1'b0;
            frame_start <= 1'b0;
            case (state)
                ST_IDLE_WAIT: begin
                    if (!line_lvl) begin
                        timer <= '0;  // Any low restarts the idle check
                    end else if (timer == IDLE_END) begin
                        timer <= '0;
                        state <= ST_ARMED;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                ST_ARMED: begin
                    timer    <= '0;
                    bit_cnt  <= '0;
                    byte_cnt <= '0;
                    if (line_evt == EVT_FALL) begin
                        state <= ST_RESET_LOW;
                    end
                end
                ST_RESET_LOW: begin
                    if (line_evt == EVT_HIGH) begin
                        state <= ST_ARMED;  // Too short for a reset
                    end else if (timer == RESET_END) begin
                        timer <= '0;
                        state <= ST_RELEASE_WAIT;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                ST_RELEASE_WAIT: begin
                    if (line_evt == EVT_HIGH) begin
                        timer <= '0;
                        state <= ST_PRES_DELAY;
                    end else if (timer == TIMEOUT_END) begin
                        state <= ST_ERROR;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                ST_PRES_DELAY: begin
                    if (line_evt != EVT_HIGH) begin
                        state <= ST_ERROR;  // Someone else took the line
                    end else if (timer == PWAIT_END) begin
                        timer    <= '0;
                        pull_low <= 1'b1;
                        state    <= ST_PRES_DRIVE;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                ST_PRES_DRIVE: begin
                    if (timer == PLEN_END) begin
                        timer       <= '0;
                        pull_low    <= 1'b0;
                        frame_start <= 1'b1;
                        state       <= ST_HIGH_WAIT;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                ST_HIGH_WAIT: begin
                    case (line_evt)
                        EVT_FALL: begin
                            timer     <= '0;
                            bit_taken <= 1'b0;
                            state     <= ST_SLOT_LOW;
                        end
                        EVT_HIGH: timer <= '0;  // Slot start may take any time
                        default: begin
                            if (timer == TIMEOUT_END) begin
                                state <= ST_ERROR;
                            end else begin
                                timer <= timer + 1'b1;
                            end
                        end
                    endcase
                end
                ST_SLOT_LOW: begin
                    timer <= timer + 1'b1;
                    if (sample_now) begin
                        bit_taken <= 1'b1;
                    end
                    if (bit_done) begin
                        timer     <= '0;
                        bit_taken <= 1'b0;
                        bit_cnt   <= bit_cnt + 1'b1;
                        state     <= ST_HIGH_WAIT;
                        if (byte_done) begin
                            rx_valid <= 1'b1;
                            if (byte_cnt == LAST_BYTE) begin
                                byte_cnt <= '0;
                                state    <= ST_IDLE_WAIT;  // Frame limit reached
                            end else begin
                                byte_cnt <= byte_cnt + 1'b1;
                            end
                        end
                    end else if ((line_evt == EVT_LOW) && (timer == SLOT_END)) begin
                        state <= ST_ERROR;
                    end
                end
                ST_ERROR: begin
                    error <= 1'b1;  // Sticky until rst_n
                    timer <= '0;
                    state <= ST_IDLE_WAIT;
                end
                default: state <= ST_IDLE_WAIT;
            endcase
        end
    end

    // Bit assembly, MSB first
    always_ff @(posedge clk) begin
        if (sample_now) begin
            shreg[3'd7 - bit_cnt] <= line_lvl;
        end
        if (byte_done) begin
            rx_byte <= shreg;
        end
    end

    a_pull_in_presence: assert property (
        @(posedge clk) disable iff (!rst_n)
        pull_low |-> (state == ST_PRES_DRIVE)
    );

    a_rx_valid_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        rx_valid |=> !rx_valid
    );

endmodule

//--- ow_slave_top.f
+incdir+.
ow_bus_pkg.sv
ow_frame_pkg.sv
ow_line_io.sv
ow_slave_fsm.sv
ow_frame_assembler.sv
ow_slave_top.sv
tb_ow_slave.sv

//--- ow_slave_top.sv
`timescale 1ns/100ps

module ow_slave_top
    import ow_frame_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     frame_ack,
    inout  wire      dq,
    output ow_word_t frame_word,
    output logic     frame_req,
    output logic     error,
    output logic     overrun
);

    logic     line_lvl;
    logic     line_fall;
    logic     pull_low;
    logic     rx_valid;
    logic     frame_start;  // Presence done, new frame begins
    ow_byte_t rx_byte;

    ow_line_io i_line_io (
        .clk       (clk),
        .rst_n     (rst_n),
        .pull_low  (pull_low),
        .dq        (dq),
        .line_lvl  (line_lvl),
        .line_fall (line_fall)
    );

    ow_slave_fsm i_slave_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .line_lvl    (line_lvl),
        .line_fall   (line_fall),
        .pull_low    (pull_low),
        .rx_valid    (rx_valid),
        .frame_start (frame_start),
        .error       (error),
        .rx_byte     (rx_byte)
    );

    ow_frame_assembler i_frame_asm (
        .clk         (clk),
        .rst_n       (rst_n),
        .rx_valid    (rx_valid),
        .frame_start (frame_start),
        .frame_ack   (frame_ack),
        .rx_byte     (rx_byte),
        .frame_word  (frame_word),
        .frame_req   (frame_req),
        .overrun     (overrun)
    );

endmodule

//--- tb_ow_slave.sv
`timescale 1ns/100ps
`include "ow_config.svh"

module tb_ow_slave
    import ow_frame_pkg::*;
();

    localparam int RESET_LEN = `OW_RESET_MIN + 500;
    localparam int SLOT_LEN  = 2000;
    localparam int PRES_AT   = `OW_PRESENCE_WAIT + 2 + `OW_GLITCH_LEN;  // Sync plus filter delay
    localparam int PRES_RUN  = RESET_LEN + PRES_AT + `OW_PRESENCE_LEN + 400;
    localparam int FRAME_RUN = PRES_RUN + 8 * `OW_FRAME_BYTES * SLOT_LEN + 300;
    // Short pulse, three frames, release timeout, slot error and three presence runs
    localparam int TEST_RUN  = 3000 + `OW_PRESENCE_WAIT + 3 * FRAME_RUN
                             + `OW_RESET_MIN + `OW_TIMEOUT + 1000 + 3 * PRES_RUN
                             + `OW_SLOT_MAX + 1000;

    logic        clk;
    logic        rst_n;
    logic        frame_ack;
    logic        master_pull;  // Master side of the open-drain bus
    wire         dq;
    ow_word_t    frame_word;
    logic        frame_req;
    logic        error;
    logic        overrun;
    logic [15:0] lfsr_q;
    ow_word_t    word_a;
    ow_word_t    word_b;
    ow_word_t    word_c;
    int          err_cnt;
    int          pass_cnt;

    pullup (dq);
    assign dq = master_pull ? 1'b0 : 1'bz;

    ow_slave_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .frame_ack  (frame_ack),
        .dq         (dq),
        .frame_word (frame_word),
        .frame_req  (frame_req),
        .error      (error),
        .overrun    (overrun)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        repeat (TEST_RUN + TEST_RUN / 5) @(posedge clk);
        $display("Watchdog expired before the tests finished");
        $display("Result: FAILED");
        $finish;
    end

    // ==============================
    // Checks and random numbers
    // ==============================
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) pass_cnt++;
        else begin
            err_cnt++;
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_true(input bit ok, input string what);
        assert (ok) pass_cnt++;
        else begin
            err_cnt++;
            $display("%0t ns: %s", $time, what);
        end
    endtask

    // Fibonacci taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [15:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            val    = {val[14:0], lfsr_q[0]};
        end
    endtask

    // ==============================
    // Master and consumer
    // ==============================
    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic reset_pulse(input int len);
        @(posedge clk);
        master_pull <= 1'b1;
        repeat (len) @(posedge clk);
        master_pull <= 1'b0;
    endtask

    task automatic write_byte(input ow_byte_t b);
        int low;
        for (int i = 7; i >= 0; i--) begin
            low = b[i] ? 150 : 1500;  // Short low for a 1
            @(posedge clk);
            master_pull <= 1'b1;
            repeat (low) @(posedge clk);
            master_pull <= 1'b0;
            repeat (SLOT_LEN - low - 1) @(posedge clk);
        end
    endtask

    // Counts negedges from the line release to the DUT's low and its length
    task automatic expect_presence();
        int delay;
        int len;
        delay = 0;
        len   = 1;
        while (delay < PRES_AT + 50) begin
            @(negedge clk);
            if (dq === 1'b0) break;
            delay++;
        end
        check_true(delay >= PRES_AT - 2 && delay <= PRES_AT + 2,
                   $sformatf("presence started after %0d cycles, not %0d", delay, PRES_AT));
        while (len < `OW_PRESENCE_LEN + 50) begin
            @(negedge clk);
            if (dq !== 1'b0) break;
            len++;
        end
        check_true(len >= `OW_PRESENCE_LEN - 2 && len <= `OW_PRESENCE_LEN + 2,
                   $sformatf("presence lasted %0d cycles, not %0d", len, `OW_PRESENCE_LEN));
    endtask

    task automatic send_frame(output ow_word_t word);
        logic [15:0] bits;
        reset_pulse(RESET_LEN);
        expect_presence();
        repeat (100) @(posedge clk);
        word = '0;
        for (int i = 0; i < `OW_FRAME_BYTES; i++) begin
            take_bits(8, bits);
            write_byte(bits[7:0]);
            word[i*8 +: 8] = bits[7:0];  // First byte in the low half
        end
    endtask

    task automatic serve_frame(input ow_word_t exp_word);
        logic [15:0] bits;
        int          cnt;
        cnt = 0;
        @(negedge clk);
        while (frame_req !== 1'b1 && cnt < 100) begin
            @(negedge clk);
            cnt++;
        end
        check_true(frame_req === 1'b1, "frame_req never rose after the last byte");
        check_value("frame_word", 32'(frame_word), 32'(exp_word));
        take_bits(4, bits);
        repeat (bits[3:0]) begin
            @(negedge clk);
            check_value("frame_req", 32'(frame_req), 32'd1);
            check_value("frame_word", 32'(frame_word), 32'(exp_word));
        end
        @(posedge clk);
        frame_ack <= 1'b1;
        @(negedge clk);
        cnt = 1;
        while (frame_req === 1'b1 && cnt < 10) begin
            @(negedge clk);
            cnt++;
        end
        check_true(cnt == 2, "frame_req did not drop one cycle after frame_ack");
        @(posedge clk);
        frame_ack <= 1'b0;
        @(negedge clk);
        check_value("frame_req", 32'(frame_req), 32'd0);
    endtask

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        bit seen_low;
        rst_n       = 1'b0;
        frame_ack   = 1'b0;
        master_pull = 1'b0;
        lfsr_q      = 16'd21;
        err_cnt     = 0;
        pass_cnt    = 0;
        seen_low    = 1'b0;
        apply_reset();
        repeat (200) @(posedge clk);

        reset_pulse(2000);  // Too short for a reset
        repeat (`OW_PRESENCE_WAIT + 500) begin
            @(negedge clk);
            seen_low = seen_low || (dq === 1'b0);
        end
        check_true(!seen_low, "presence pulse after a low too short for reset");
        check_value("error", 32'(error), 32'd0);

        send_frame(word_a);
        serve_frame(word_a);
        check_value("overrun", 32'(overrun), 32'd0);

        // Consumer holds off, the next frame must be dropped
        repeat (200) @(posedge clk);
        send_frame(word_b);
        @(negedge clk);
        check_value("frame_word", 32'(frame_word), 32'(word_b));
        repeat (200) @(posedge clk);
        send_frame(word_c);
        @(negedge clk);
        check_value("overrun", 32'(overrun), 32'd1);
        check_value("frame_word", 32'(frame_word), 32'(word_b));
        serve_frame(word_b);

        repeat (200) @(posedge clk);
        reset_pulse(`OW_RESET_MIN + `OW_TIMEOUT + 1000);  // Release never comes in time
        @(negedge clk);
        check_value("error", 32'(error), 32'd1);
        repeat (200) @(posedge clk);
        reset_pulse(RESET_LEN);
        expect_presence();

        apply_reset();
        @(negedge clk);
        check_value("error", 32'(error), 32'd0);
        check_value("overrun", 32'(overrun), 32'd0);
        repeat (200) @(posedge clk);
        reset_pulse(RESET_LEN);
        expect_presence();
        repeat (100) @(posedge clk);
        reset_pulse(`OW_SLOT_MAX + 500);  // Slot held low too long
        @(negedge clk);
        check_value("error", 32'(error), 32'd1);
        repeat (200) @(posedge clk);
        reset_pulse(RESET_LEN);
        expect_presence();

        $display("Checks passed: %0d, errors: %0d", pass_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
